//--- unwrap_pkg.sv
package unwrap_pkg;

	typedef logic [63:0] block_t; // one xtea block, one record beat
	typedef logic [127:0] xtea_key_t;
	typedef logic [31:0] rsa_word_t; // exponent, modulus, wrapped and session keys
	typedef logic [7:0] char_t;

	// decrypted parameter block, exponent in the upper word
	typedef struct packed {
		rsa_word_t exponent;
		rsa_word_t modulus;
	} rsa_params_t;

	// keyboard strobe bundle
	typedef struct packed {
		logic valid;
		logic done; // enter key
		logic clear; // discard typed characters
		char_t data;
	} ps2_char_t;

	typedef enum logic [2:0] {
		LOAD_RECORD,
		READ_PASS,
		CHECK_PASS,
		DECRYPT_PARAMS,
		WAIT_KEY,
		MODEXP,
		OFFER_KEY
	} phase_e;

	// plaintext of the check block under the right passphrase
	localparam block_t CHECK_MAGIC = 64'h4b45_5955_4e57_5250;

	localparam int MAX_CHARS = 16; // 128-bit key, 8 bits per character

endpackage

//--- unwrap_counter.sv
`timescale 1ns/1ns

module unwrap_counter #(
	parameter int CNT_W = 4
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic clear_i,
	input logic inc_i,
	input logic [CNT_W-1:0] limit_i,
	output logic [CNT_W-1:0] cnt_o,
	output logic last_o
);

	logic [CNT_W-1:0] cnt_q;

	assign cnt_o = cnt_q;
	assign last_o = inc_i && (cnt_q == limit_i - 1'b1); // final increment this cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q <= '0;
		end else if (en_i) begin
			if (clear_i) begin
				cnt_q <= '0;
			end else if (inc_i && (cnt_q < limit_i)) begin
				cnt_q <= cnt_q + 1'b1; // saturates at the limit
			end
		end
	end

	// limit comes from the FSM, count must stay within it
	assert property (@(posedge clk) disable iff (rst) cnt_q <= limit_i)
		else $error("counter above limit");

endmodule

//--- unwrap_fsm.sv
`timescale 1ns/1ns

module unwrap_fsm #(
	parameter int CNT_W = 4
) (
	input logic clk,
	input logic rst,
	input logic stall_i,
	input logic rec_valid_i,
	output logic rec_ready_o,
	input logic wkey_valid_i,
	output logic wkey_ready_o,
	input logic out_ready_i,
	output logic skey_valid_o,
	input logic pass_done_i,
	output logic pass_accept_o,
	output logic pass_clear_o,
	output logic cnt_clear_o,
	output logic cnt_inc_o,
	output logic [CNT_W-1:0] cnt_limit_o,
	input logic cnt_last_i,
	output logic rec_we_o,
	output logic check_we_o,
	output logic params_we_o,
	output logic xtea_start_o,
	output logic xtea_sel_o,
	input logic xtea_done_i,
	input logic check_ok_i,
	output logic mx_start_o,
	input logic mx_done_i,
	output logic led_pass_o,
	output logic led_fail_o
);

	unwrap_pkg::phase_e state_q;
	logic rec_rdy_q;
	logic wkey_rdy_q;
	logic skey_vld_q;
	logic check_pend_q; // check result lands one cycle after xtea done
	logic run;
	logic rec_fire;
	logic wkey_fire;
	logic out_fire;

	assign run = !stall_i;

	// no transfer on any port while stalled
	assign rec_ready_o = rec_rdy_q && run;
	assign wkey_ready_o = wkey_rdy_q && run;
	assign skey_valid_o = skey_vld_q && run;

	assign rec_fire = rec_valid_i && rec_ready_o;
	assign wkey_fire = wkey_valid_i && wkey_ready_o;
	assign out_fire = skey_valid_o && out_ready_i;

	assign cnt_limit_o = CNT_W'(2); // check beat, then parameter beat
	assign cnt_inc_o = rec_fire;
	assign cnt_clear_o = rec_fire && cnt_last_i;
	assign rec_we_o = rec_fire;

	assign pass_accept_o = (state_q == unwrap_pkg::READ_PASS);
	assign pass_clear_o = run && check_pend_q && !check_ok_i
		&& (state_q == unwrap_pkg::CHECK_PASS);
	assign check_we_o = run && xtea_done_i && (state_q == unwrap_pkg::CHECK_PASS);
	assign params_we_o = run && xtea_done_i && (state_q == unwrap_pkg::DECRYPT_PARAMS);
	assign mx_start_o = wkey_fire; // base is taken straight from the port

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= unwrap_pkg::LOAD_RECORD;
			rec_rdy_q <= 1'b1;
			wkey_rdy_q <= 1'b0;
			skey_vld_q <= 1'b0;
			check_pend_q <= 1'b0;
			xtea_start_o <= 1'b0;
			xtea_sel_o <= 1'b0;
			led_pass_o <= 1'b0;
			led_fail_o <= 1'b0;
		end else if (run) begin
			xtea_start_o <= 1'b0;
			case (state_q)
				unwrap_pkg::LOAD_RECORD: begin
					if (rec_fire && cnt_last_i) begin
						rec_rdy_q <= 1'b0;
						state_q <= unwrap_pkg::READ_PASS;
					end
				end
				unwrap_pkg::READ_PASS: begin
					if (pass_done_i) begin
						xtea_start_o <= 1'b1;
						xtea_sel_o <= 1'b0; // check block first
						state_q <= unwrap_pkg::CHECK_PASS;
					end
				end
				unwrap_pkg::CHECK_PASS: begin
					if (check_pend_q) begin
						check_pend_q <= 1'b0;
						if (check_ok_i) begin
							led_pass_o <= 1'b1;
							xtea_start_o <= 1'b1;
							xtea_sel_o <= 1'b1;
							state_q <= unwrap_pkg::DECRYPT_PARAMS;
						end else begin
							led_fail_o <= 1'b1; // sticky
							state_q <= unwrap_pkg::READ_PASS;
						end
					end else if (xtea_done_i) begin
						check_pend_q <= 1'b1;
					end
				end
				unwrap_pkg::DECRYPT_PARAMS: begin
					if (xtea_done_i) begin
						wkey_rdy_q <= 1'b1;
						state_q <= unwrap_pkg::WAIT_KEY;
					end
				end
				unwrap_pkg::WAIT_KEY: begin
					if (wkey_fire) begin
						wkey_rdy_q <= 1'b0;
						state_q <= unwrap_pkg::MODEXP;
					end
				end
				unwrap_pkg::MODEXP: begin
					if (mx_done_i) begin
						skey_vld_q <= 1'b1;
						state_q <= unwrap_pkg::OFFER_KEY;
					end
				end
				unwrap_pkg::OFFER_KEY: begin
					if (out_fire) begin
						skey_vld_q <= 1'b0;
						wkey_rdy_q <= 1'b1; // next wrapped key may enter
						state_q <= unwrap_pkg::WAIT_KEY;
					end
				end
				default: state_q <= unwrap_pkg::LOAD_RECORD;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) xtea_start_o && run |=> !xtea_start_o)
		else $error("xtea start longer than one cycle");

	assert property (@(posedge clk) disable iff (rst) mx_start_o |=> !mx_start_o)
		else $error("modexp start longer than one cycle");

	// offered session key is held until the consumer takes it
	assert property (@(posedge clk) disable iff (rst) skey_vld_q && !out_fire |=> skey_vld_q)
		else $error("session key dropped before accept");

endmodule

//--- key_buffer.sv
`timescale 1ns/1ns

module key_buffer (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic rec_we_i,
	input logic beat_i,
	input unwrap_pkg::block_t rec_data_i,
	input logic check_we_i,
	input logic params_we_i,
	input unwrap_pkg::block_t plain_i,
	output unwrap_pkg::block_t check_block_o,
	output unwrap_pkg::block_t param_block_o,
	output logic check_ok_o,
	output unwrap_pkg::rsa_params_t params_o
);

	// wrapped beats and the recovered parameters
	always_ff @(posedge clk) begin
		if (en_i) begin
			if (rec_we_i && !beat_i) begin
				check_block_o <= rec_data_i; // beat 0
			end
			if (rec_we_i && beat_i) begin
				param_block_o <= rec_data_i; // beat 1
			end
			if (params_we_i) begin
				params_o <= unwrap_pkg::rsa_params_t'(plain_i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			check_ok_o <= 1'b0;
		end else if (en_i && check_we_i) begin
			check_ok_o <= (plain_i == unwrap_pkg::CHECK_MAGIC);
		end
	end

endmodule

//--- passphrase_buffer.sv
`timescale 1ns/1ns

module passphrase_buffer (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic accept_i,
	input logic clear_i,
	input unwrap_pkg::ps2_char_t ps2_i,
	output unwrap_pkg::xtea_key_t key_o,
	output logic done_o
);

	localparam int IDX_W = $clog2(unwrap_pkg::MAX_CHARS + 1);

	unwrap_pkg::xtea_key_t key_q;
	logic [IDX_W-1:0] idx_q; // next character slot
	logic locked_q; // entry finished, key frozen
	logic take;

	assign take = accept_i && ps2_i.valid;
	assign key_o = key_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			key_q <= '0;
			idx_q <= '0;
			locked_q <= 1'b0;
			done_o <= 1'b0;
		end else if (en_i) begin
			done_o <= 1'b0;
			if (clear_i || (take && ps2_i.clear)) begin
				key_q <= '0; // padding stays zero
				idx_q <= '0;
				locked_q <= 1'b0;
			end else if (take && !locked_q) begin
				if (ps2_i.done) begin
					done_o <= 1'b1;
					locked_q <= 1'b1;
				end else begin
					key_q[8 * idx_q +: 8] <= ps2_i.data;
					idx_q <= idx_q + 1'b1;
					if (idx_q == IDX_W'(unwrap_pkg::MAX_CHARS - 1)) begin
						done_o <= 1'b1; // buffer full
						locked_q <= 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- xtea_decrypt.sv
`timescale 1ns/1ns

module xtea_decrypt #(
	parameter int NUM_ROUNDS = 32
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic start_i,
	input unwrap_pkg::xtea_key_t key_i,
	input unwrap_pkg::block_t block_i,
	output unwrap_pkg::block_t block_o,
	output logic done_o
);

	localparam logic [31:0] DELTA = 32'h9e37_79b9;
	localparam logic [31:0] SUM_INIT = DELTA * NUM_ROUNDS; // wraps mod 2^32
	localparam int RND_W = $clog2(NUM_ROUNDS + 1);

	logic [31:0] v0_q;
	logic [31:0] v1_q;
	logic [31:0] sum_q;
	logic [31:0] v0_n;
	logic [31:0] v1_n;
	logic [31:0] sum_n;
	logic [31:0] k_hi; // key word picked by sum bits 12:11
	logic [31:0] k_lo; // key word picked by sum bits 1:0
	unwrap_pkg::xtea_key_t key_q;
	logic [RND_W-1:0] rnd_q;
	logic busy_q;

	assign k_hi = key_q[{sum_q[12:11], 5'd0} +: 32];
	assign k_lo = key_q[{sum_n[1:0], 5'd0} +: 32];

	// one full round, both halves
	assign v1_n = v1_q - ((((v0_q << 4) ^ (v0_q >> 5)) + v0_q) ^ (sum_q + k_hi));
	assign sum_n = sum_q - DELTA;
	assign v0_n = v0_q - ((((v1_n << 4) ^ (v1_n >> 5)) + v1_n) ^ (sum_n + k_lo));

	assign block_o = {v0_q, v1_q};

	always_ff @(posedge clk) begin
		if (en_i) begin
			if (start_i) begin
				{v0_q, v1_q} <= block_i;
				sum_q <= SUM_INIT;
				key_q <= key_i;
			end else if (busy_q) begin
				v0_q <= v0_n;
				v1_q <= v1_n;
				sum_q <= sum_n;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			rnd_q <= '0;
			done_o <= 1'b0;
		end else if (en_i) begin
			done_o <= 1'b0;
			if (start_i) begin
				busy_q <= 1'b1;
				rnd_q <= '0;
			end else if (busy_q) begin
				rnd_q <= rnd_q + 1'b1;
				if (rnd_q == RND_W'(NUM_ROUNDS - 1)) begin
					busy_q <= 1'b0;
					done_o <= 1'b1; // block_o holds the plaintext
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) start_i && en_i |-> !busy_q)
		else $error("xtea started while busy");

endmodule

//--- mod_exp.sv
`timescale 1ns/1ns

module mod_exp (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic start_i,
	input unwrap_pkg::rsa_word_t base_i,
	input unwrap_pkg::rsa_word_t exp_i,
	input unwrap_pkg::rsa_word_t mod_i,
	output unwrap_pkg::rsa_word_t result_o,
	output logic done_o
);

	typedef enum logic [1:0] {
		MX_IDLE,
		MX_REDUCE,
		MX_MUL,
		MX_SQR
	} mx_state_e;

	mx_state_e state_q;
	unwrap_pkg::rsa_word_t base_q;
	unwrap_pkg::rsa_word_t exp_q; // remaining exponent bits
	unwrap_pkg::rsa_word_t mod_q;
	unwrap_pkg::rsa_word_t acc_q;
	unwrap_pkg::rsa_word_t mul_a;
	unwrap_pkg::rsa_word_t mul_b;
	unwrap_pkg::rsa_word_t prod_mod;
	logic [63:0] prod;
	logic [63:0] rem;

	// single shared multiplier and remainder
	assign mul_a = (state_q == MX_MUL) ? acc_q : base_q;
	assign mul_b = (state_q == MX_REDUCE) ? 32'd1 : base_q;
	assign prod = {32'd0, mul_a} * {32'd0, mul_b};
	assign rem = prod % {32'd0, mod_q};
	assign prod_mod = rem[31:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= MX_IDLE;
			done_o <= 1'b0;
		end else if (en_i) begin
			done_o <= 1'b0;
			case (state_q)
				MX_IDLE: if (start_i) state_q <= MX_REDUCE;
				MX_REDUCE: begin
					if (exp_q == '0) begin
						state_q <= MX_IDLE;
						done_o <= 1'b1;
					end else begin
						state_q <= MX_MUL;
					end
				end
				MX_MUL: state_q <= MX_SQR;
				MX_SQR: begin
					if (exp_q[31:1] == '0) begin
						state_q <= MX_IDLE; // no set bits left
						done_o <= 1'b1;
					end else begin
						state_q <= MX_MUL;
					end
				end
				default: state_q <= MX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (en_i) begin
			case (state_q)
				MX_IDLE: begin
					if (start_i) begin
						base_q <= base_i;
						exp_q <= exp_i;
						mod_q <= mod_i;
						acc_q <= (mod_i == 32'd1) ? 32'd0 : 32'd1; // 1 mod m
					end
				end
				MX_REDUCE: begin
					base_q <= prod_mod;
					if (exp_q == '0) result_o <= acc_q;
				end
				MX_MUL: if (exp_q[0]) acc_q <= prod_mod;
				MX_SQR: begin
					base_q <= prod_mod;
					exp_q <= exp_q >> 1;
					if (exp_q[31:1] == '0) result_o <= acc_q; // held until next done
				end
				default: ;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		start_i && en_i && (state_q == MX_IDLE) |-> mod_i != '0)
		else $error("modexp started with zero modulus");

endmodule

//--- unwrap_top.sv
`timescale 1ns/1ns

module unwrap_top #(
	parameter int NUM_ROUNDS = 32,
	parameter int CNT_W = 4
) (
	input logic clk,
	input logic rst,
	input logic stall_i,
	input unwrap_pkg::block_t rec_data_i,
	input logic rec_valid_i,
	output logic rec_ready_o,
	input unwrap_pkg::ps2_char_t ps2_i,
	input unwrap_pkg::rsa_word_t wkey_data_i,
	input logic wkey_valid_i,
	output logic wkey_ready_o,
	output unwrap_pkg::rsa_word_t skey_data_o,
	output logic skey_valid_o,
	input logic out_ready_i,
	output logic led_pass_o,
	output logic led_fail_o
);

	logic pass_done;
	logic pass_accept;
	logic pass_clear;
	logic cnt_clear;
	logic cnt_inc;
	logic cnt_last;
	logic [CNT_W-1:0] cnt_limit;
	logic [CNT_W-1:0] cnt;
	logic rec_we;
	logic check_we;
	logic params_we;
	logic xtea_start;
	logic xtea_sel; // 0 check block, 1 parameter block
	logic xtea_done;
	logic check_ok;
	logic mx_start;
	logic mx_done;
	unwrap_pkg::xtea_key_t pass_key;
	unwrap_pkg::block_t plain;
	unwrap_pkg::block_t check_block;
	unwrap_pkg::block_t param_block;
	unwrap_pkg::rsa_params_t params;

	unwrap_fsm #(.CNT_W(CNT_W)) u_fsm (
		.clk, .rst, .stall_i,
		.rec_valid_i, .rec_ready_o,
		.wkey_valid_i, .wkey_ready_o,
		.out_ready_i, .skey_valid_o,
		.pass_done_i(pass_done), .pass_accept_o(pass_accept), .pass_clear_o(pass_clear),
		.cnt_clear_o(cnt_clear), .cnt_inc_o(cnt_inc), .cnt_limit_o(cnt_limit),
		.cnt_last_i(cnt_last),
		.rec_we_o(rec_we), .check_we_o(check_we), .params_we_o(params_we),
		.xtea_start_o(xtea_start), .xtea_sel_o(xtea_sel), .xtea_done_i(xtea_done),
		.check_ok_i(check_ok),
		.mx_start_o(mx_start), .mx_done_i(mx_done),
		.led_pass_o, .led_fail_o
	);

	unwrap_counter #(.CNT_W(CNT_W)) u_counter (
		.clk, .rst, .en_i(!stall_i),
		.clear_i(cnt_clear), .inc_i(cnt_inc), .limit_i(cnt_limit),
		.cnt_o(cnt), .last_o(cnt_last)
	);

	key_buffer u_key_buffer (
		.clk, .rst, .en_i(!stall_i),
		.rec_we_i(rec_we), .beat_i(cnt[0]), .rec_data_i,
		.check_we_i(check_we), .params_we_i(params_we), .plain_i(plain),
		.check_block_o(check_block), .param_block_o(param_block),
		.check_ok_o(check_ok), .params_o(params)
	);

	passphrase_buffer u_pass_buffer (
		.clk, .rst, .en_i(!stall_i),
		.accept_i(pass_accept), .clear_i(pass_clear), .ps2_i,
		.key_o(pass_key), .done_o(pass_done)
	);

	xtea_decrypt #(.NUM_ROUNDS(NUM_ROUNDS)) u_xtea (
		.clk, .rst, .en_i(!stall_i),
		.start_i(xtea_start), .key_i(pass_key),
		.block_i(xtea_sel ? param_block : check_block),
		.block_o(plain), .done_o(xtea_done)
	);

	mod_exp u_mod_exp (
		.clk, .rst, .en_i(!stall_i),
		.start_i(mx_start), .base_i(wkey_data_i),
		.exp_i(params.exponent), .mod_i(params.modulus),
		.result_o(skey_data_o), .done_o(mx_done)
	);

endmodule

//--- tb_unwrap_ref.svh
`ifndef TB_UNWRAP_REF_SVH
`define TB_UNWRAP_REF_SVH

// block is {v0, v1} with key word i at bits 32i and up
function automatic unwrap_pkg::block_t encrypt_block(unwrap_pkg::block_t blk,
		unwrap_pkg::xtea_key_t key, int rounds);
	logic [31:0] v0 = blk[63:32];
	logic [31:0] v1 = blk[31:0];
	logic [31:0] sum = 32'd0;
	for (int i = 0; i < rounds; i++) begin
		v0 += (((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + key[{sum[1:0], 5'd0} +: 32]);
		sum += 32'h9e37_79b9;
		v1 += (((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + key[{sum[12:11], 5'd0} +: 32]);
	end
	return {v0, v1};
endfunction

function automatic unwrap_pkg::block_t decrypt_block(unwrap_pkg::block_t blk,
		unwrap_pkg::xtea_key_t key, int rounds);
	logic [31:0] v0 = blk[63:32];
	logic [31:0] v1 = blk[31:0];
	logic [31:0] sum = 32'h9e37_79b9 * rounds;
	for (int i = 0; i < rounds; i++) begin
		v1 -= (((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + key[{sum[12:11], 5'd0} +: 32]);
		sum -= 32'h9e37_79b9;
		v0 -= (((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + key[{sum[1:0], 5'd0} +: 32]);
	end
	return {v0, v1};
endfunction

// right to left square and multiply
function automatic unwrap_pkg::rsa_word_t power_mod(unwrap_pkg::rsa_word_t base,
		unwrap_pkg::rsa_word_t exp, unwrap_pkg::rsa_word_t mod);
	logic [63:0] r = 64'd1 % mod;
	logic [63:0] b = base % mod;
	logic [31:0] e = exp;
	while (e != 32'd0) begin
		if (e[0]) r = (r * b) % mod;
		b = (b * b) % mod;
		e = e >> 1;
	end
	return r[31:0];
endfunction

// character n at bits 8n with zero padding above
function automatic unwrap_pkg::xtea_key_t pack_passphrase(string pass);
	unwrap_pkg::xtea_key_t key = '0;
	for (int i = 0; i < pass.len() && i < unwrap_pkg::MAX_CHARS; i++) begin
		key[8 * i +: 8] = pass[i];
	end
	return key;
endfunction

function automatic unwrap_pkg::block_t pack_params(unwrap_pkg::rsa_word_t exponent,
		unwrap_pkg::rsa_word_t modulus);
	return {exponent, modulus}; // same layout as rsa_params_t
endfunction

`endif

//--- tb_unwrap.sv
`timescale 1ns/1ns

module tb_unwrap;

	localparam int NUM_ROUNDS = 32;
	localparam int CNT_W = 4;
	localparam int TIMEOUT = 1000; // cycles allowed per wait
	localparam int NUM_ENTRIES = 5;

	typedef struct {
		string secret; // passphrase the record is wrapped with
		string junk; // typed first and dropped by a clear strobe
		string typed;
		bit ok;
		unwrap_pkg::rsa_word_t exponent;
		unwrap_pkg::rsa_word_t modulus;
		int nkeys;
	} entry_t;

	logic clk;
	logic rst;
	logic stall_i;
	unwrap_pkg::block_t rec_data_i;
	logic rec_valid_i;
	logic rec_ready_o;
	unwrap_pkg::ps2_char_t ps2_i;
	unwrap_pkg::rsa_word_t wkey_data_i;
	logic wkey_valid_i;
	logic wkey_ready_o;
	unwrap_pkg::rsa_word_t skey_data_o;
	logic skey_valid_o;
	logic out_ready_i;
	logic led_pass_o;
	logic led_fail_o;

	logic stall_en; // random stall pulses allowed
	logic fail_seen; // fail LED expected from an earlier entry
	unwrap_pkg::rsa_word_t sess_exp;
	unwrap_pkg::rsa_word_t sess_mod;
	entry_t tbl [NUM_ENTRIES];

	`include "tb_unwrap_ref.svh"

	unwrap_top #(.NUM_ROUNDS(NUM_ROUNDS), .CNT_W(CNT_W)) dut (
		.clk, .rst, .stall_i,
		.rec_data_i, .rec_valid_i, .rec_ready_o,
		.ps2_i,
		.wkey_data_i, .wkey_valid_i, .wkey_ready_o,
		.skey_data_o, .skey_valid_o, .out_ready_i,
		.led_pass_o, .led_fail_o
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// one random stall decision per cycle
	initial begin
		forever begin
			@(posedge clk);
			#1;
			stall_i = stall_en && (($urandom % 4) == 0);
		end
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reset_dut();
		stall_en = 1'b0;
		stall_i = 1'b0;
		rst = 1'b1;
		rec_data_i = '0;
		rec_valid_i = 1'b0;
		ps2_i = '0;
		wkey_data_i = '0;
		wkey_valid_i = 1'b0;
		out_ready_i = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic send_beat(input unwrap_pkg::block_t beat);
		int t;
		@(posedge clk);
		#1;
		rec_data_i = beat;
		rec_valid_i = 1'b1;
		t = 0;
		@(negedge clk);
		while (!rec_ready_o && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		assert (rec_ready_o) else fail_now("timeout waiting for rec_ready_o");
		@(posedge clk); // beat transfers here
		#1;
		rec_valid_i = 1'b0;
	endtask

	task automatic start_session(input entry_t e);
		unwrap_pkg::xtea_key_t key;
		key = pack_passphrase(e.secret);
		sess_exp = e.exponent;
		sess_mod = e.modulus;
		fail_seen = 1'b0;
		reset_dut();
		@(negedge clk);
		assert (rec_ready_o && !wkey_ready_o && !skey_valid_o && !led_pass_o && !led_fail_o)
			else fail_now($sformatf("ERROR at %0t ns: outputs not at reset values", $time));
		stall_en = 1'b1;
		send_beat(encrypt_block(unwrap_pkg::CHECK_MAGIC, key, NUM_ROUNDS));
		send_beat(encrypt_block(pack_params(e.exponent, e.modulus), key, NUM_ROUNDS));
		@(negedge clk);
		assert (!rec_ready_o)
			else fail_now($sformatf("ERROR at %0t ns: rec_ready_o high after record", $time));
	endtask

	task automatic strobe_char(input logic done, input logic clr, input unwrap_pkg::char_t ch);
		ps2_i = {1'b1, done, clr, ch};
		@(posedge clk);
		#1;
		ps2_i = '0;
	endtask

	task automatic type_pass(input entry_t e);
		int i;
		stall_en = 1'b0; // keyboard strobes have no back-pressure
		@(posedge clk);
		#1;
		for (i = 0; i < e.junk.len(); i++) begin
			strobe_char(1'b0, 1'b0, e.junk[i]);
		end
		if (e.junk.len() > 0) begin
			strobe_char(1'b0, 1'b1, 8'h00);
		end
		for (i = 0; i < e.typed.len(); i++) begin
			strobe_char(1'b0, 1'b0, e.typed[i]);
		end
		if (e.typed.len() < unwrap_pkg::MAX_CHARS) begin
			strobe_char(1'b1, 1'b0, 8'h0d); // enter
		end
	endtask

	task automatic check_result(input bit ok);
		int t;
		stall_en = 1'b1;
		t = 0;
		@(negedge clk);
		while (!(ok ? led_pass_o : led_fail_o) && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (ok) begin
			assert (led_pass_o) else fail_now("timeout waiting for the pass LED");
			assert (led_fail_o == fail_seen) else fail_now($sformatf(
				"ERROR at %0t ns: fail LED %b, expected %b", $time, led_fail_o, fail_seen));
		end else begin
			assert (led_fail_o) else fail_now("timeout waiting for the fail LED");
			assert (!led_pass_o)
				else fail_now($sformatf("ERROR at %0t ns: pass LED on wrong passphrase", $time));
			fail_seen = 1'b1;
		end
	endtask

	task automatic run_key(input int idx);
		unwrap_pkg::rsa_word_t wkey;
		unwrap_pkg::rsa_word_t expect_key;
		unwrap_pkg::rsa_word_t got;
		int t;
		wkey = $urandom;
		expect_key = power_mod(wkey, sess_exp, sess_mod);
		stall_en = 1'b1;
		@(posedge clk);
		#1;
		wkey_data_i = wkey;
		wkey_valid_i = 1'b1;
		t = 0;
		@(negedge clk);
		while (!wkey_ready_o && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		assert (wkey_ready_o) else fail_now("timeout waiting for wkey_ready_o");
		@(posedge clk);
		#1;
		wkey_valid_i = 1'b0;
		t = 0;
		@(negedge clk);
		while (!skey_valid_o && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		assert (skey_valid_o) else fail_now("timeout waiting for skey_valid_o");
		stall_en = 1'b0; // offer must stay visible while held
		got = skey_data_o;
		assert (got == expect_key) else fail_now($sformatf(
			"ERROR at %0t ns: session key %0d is %h, expected %h", $time, idx, got, expect_key));
		// even keys are held back for a few cycles
		repeat ((idx % 2 == 0) ? 4 : 0) begin
			@(negedge clk);
			assert (skey_valid_o && skey_data_o == got && !wkey_ready_o) else fail_now(
				$sformatf("ERROR at %0t ns: held session key %0d not stable", $time, idx));
		end
		@(posedge clk);
		#1;
		out_ready_i = 1'b1;
		@(negedge clk);
		assert (skey_valid_o)
			else fail_now($sformatf("ERROR at %0t ns: skey_valid_o dropped before accept", $time));
		@(posedge clk);
		#1;
		out_ready_i = 1'b0;
	endtask

	initial begin
		int i;
		int k;
		void'($urandom(32'h40fb));
		reset_dut();
		tbl[0] = '{"open sesame", "", "letmein", 1'b0, 32'h0001_0001, 32'hffff_fffb, 0};
		tbl[1] = '{"open sesame", "xyz", "open sesame", 1'b1, 32'h0001_0001, 32'hffff_fffb, 4};
		tbl[2] = '{"0123456789abcdef", "", "0123456789abcdef", 1'b1,
			32'hdead_beef, 32'hc000_0001, 3};
		tbl[3] = '{"zz", "", "wrongwrongwrong!", 1'b0, 32'd0, 32'd97, 0};
		tbl[4] = '{"zz", "", "zz", 1'b1, 32'd0, 32'd97, 2};
		for (i = 0; i < NUM_ENTRIES; i++) begin
			if (i == 0 || tbl[i - 1].ok) begin
				start_session(tbl[i]); // fresh record after each unlock
			end
			type_pass(tbl[i]);
			check_result(tbl[i].ok);
			for (k = 0; k < tbl[i].nkeys; k++) begin
				run_key(k);
			end
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- all.f
+incdir+.
unwrap_pkg.sv
unwrap_counter.sv
unwrap_fsm.sv
key_buffer.sv
passphrase_buffer.sv
xtea_decrypt.sv
mod_exp.sv
unwrap_top.sv
tb_unwrap.sv

//--- Bender.yml
package:
  name: unwrap_ctrl

sources:
  - files:
      - unwrap_pkg.sv
      - unwrap_counter.sv
      - unwrap_fsm.sv
      - key_buffer.sv
      - passphrase_buffer.sv
      - xtea_decrypt.sv
      - mod_exp.sv
      - unwrap_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_unwrap.sv
